// File: rv_exec_top.f
logic/rv_exec_pkg.sv
logic/instr_decoder.sv
logic/issue_stage.sv
logic/alu.sv
logic/branch_unit.sv
logic/result_stage.sv
logic/rv_exec_top.sv
sim/rv_exec_checker.sv
sim/rv_exec_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the rv_exec_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Mdir "$BUILD" --top-module rv_exec_tb -f rv_exec_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD/Vrv_exec_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/rv_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int CTR_WIDTH   = 32;
    localparam int TEST_CYCLES = 200;
    localparam int CYCLE_LIMIT = 10 * TEST_CYCLES;

    logic                 clk;
    logic                 arst_n;
    logic                 instr_valid;
    logic [XLEN-1:0]      instr;
    logic [XLEN-1:0]      pc;
    redirect_t            redirect;
    retire_t              retire;
    logic [CTR_WIDTH-1:0] cycle_count;
    logic [CTR_WIDTH-1:0] retire_count;

    // Reference model and expectations
    logic [XLEN-1:0]      model_regs [0:31];
    retire_t              exp_retire [$];
    logic [XLEN-1:0]      exp_target [$];
    logic [XLEN-1:0]      fetch_pc;
    logic [XLEN-1:0]      jump_to;
    logic                 squash_next;
    logic [CTR_WIDTH-1:0] since_reset = '0;
    logic [CTR_WIDTH-1:0] retires_seen = '0;
    int                   sim_cycles = 0;
    integer               seed;
    string                test_name;
    int                   test_errors;
    int                   total_errors;
    int                   tests_run;
    int                   tests_failed;

    rv_exec_top #(.CTR_WIDTH(CTR_WIDTH)) dut0 (
        .clk(clk), .arst_n(arst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .redirect(redirect), .retire(retire),
        .cycle_count(cycle_count), .retire_count(retire_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        sim_cycles <= sim_cycles + 1;
        if (arst_n) begin
            since_reset <= since_reset + CTR_WIDTH'(1);
        end
        if (sim_cycles == CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Encoders
    //////////////////////////////
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // RV32I semantics on the model registers
    task automatic predict(input logic [XLEN-1:0] w, input logic [XLEN-1:0] p,
                           output logic [XLEN-1:0] val, output logic we,
                           output logic br, output logic [XLEN-1:0] tgt);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [4:0]      sh;
        a     = model_regs[w[19:15]];
        imm_i = {{20{w[31]}}, w[31:20]};
        b     = (w[6:0] == OPC_OP || w[6:0] == OPC_BRANCH) ? model_regs[w[24:20]] : imm_i;
        sh    = b[4:0];
        val   = '0;
        we    = 1'b1;
        br    = 1'b0;
        tgt   = p + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                case (w[14:12])
                    3'd0:    val = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
                    3'd1:    val = a << sh;
                    3'd2:    val = {31'd0, $signed(a) < $signed(b)};
                    3'd3:    val = {31'd0, a < b};
                    3'd4:    val = a ^ b;
                    3'd5:    val = w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
                    3'd6:    val = a | b;
                    default: val = a & b;
                endcase
            end
            OPC_LUI:   val = {w[31:12], 12'd0};
            OPC_AUIPC: val = p + {w[31:12], 12'd0};
            OPC_BRANCH: begin
                we = 1'b0;
                case (w[14:12])
                    3'd0:    br = a == b;
                    3'd1:    br = a != b;
                    3'd4:    br = $signed(a) < $signed(b);
                    3'd5:    br = $signed(a) >= $signed(b);
                    3'd6:    br = a < b;
                    default: br = a >= b;
                endcase
            end
            OPC_JAL: begin
                val = p + 32'd4;
                br  = 1'b1;
                tgt = p + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                val = p + 32'd4;
                br  = 1'b1;
                tgt = (a + imm_i) & ~32'd1;
            end
        endcase
    endtask

    //////////////////////////////
    // Fetcher side
    //////////////////////////////
    task automatic send(input logic [XLEN-1:0] word);
        logic [XLEN-1:0] val;
        logic            we;
        logic            br;
        logic [XLEN-1:0] tgt;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= fetch_pc;
        if (squash_next) begin
            // Presented while the redirect is up
            squash_next = 1'b0;
            fetch_pc    = jump_to;
        end else begin
            predict(word, fetch_pc, val, we, br, tgt);
            if (we && word[11:7] != 5'd0) begin
                model_regs[word[11:7]] = val;
            end
            exp_retire.push_back('{valid: 1'b1, pc: fetch_pc, rd: word[11:7],
                                   value: val, reg_we: we});
            if (br) begin
                exp_target.push_back(tgt);
                squash_next = 1'b1;
                jump_to     = tgt;
            end
            fetch_pc = fetch_pc + 32'd4;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid <= 1'b0;
        if (squash_next) begin
            squash_next = 1'b0;
            fetch_pc    = jump_to;
        end
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual == expected) else begin
            $display("Error in %s, %s: expected %h, actual %h", test_name, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        while (exp_retire.size() != 0) begin
            idle();
        end
        idle();
        if (exp_target.size() != 0) begin
            $display("Test %s: %0d expected redirects never appeared", test_name,
                     exp_target.size());
            test_errors++;
            exp_target.delete();
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %-9s %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failing", test_errors);
    endtask

    // Outputs are compared mid-cycle
    always @(negedge clk) begin : monitor
        retire_t want;
        if (arst_n) begin
            check_value("cycle_count", since_reset, cycle_count);
            check_value("retire_count", retires_seen, retire_count);
            if (retire.valid) begin
                retires_seen = retires_seen + CTR_WIDTH'(1);
                if (exp_retire.size() == 0) begin
                    $display("Test %s: pc %h retired but no retire was expected",
                             test_name, retire.pc);
                    test_errors++;
                end else begin
                    want = exp_retire.pop_front();
                    check_value("retire pc", want.pc, retire.pc);
                    check_value("retire reg_we", 32'(want.reg_we), 32'(retire.reg_we));
                    if (want.reg_we) begin
                        check_value("retire rd", 32'(want.rd), 32'(retire.rd));
                        check_value("retire value", want.value, retire.value);
                    end
                end
            end
            if (redirect.valid) begin
                if (exp_target.size() == 0) begin
                    $display("Test %s: redirect to %h with no taken branch or jump",
                             test_name, redirect.target);
                    test_errors++;
                end else begin
                    check_value("redirect target", exp_target.pop_front(), redirect.target);
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [11:0] imm12;
        logic [4:0]  rs_a;
        logic [4:0]  rs_b;
        int          i;
        int          k;
        seed         = 73;
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        fetch_pc     = 32'h0000_1000;
        jump_to      = '0;
        squash_next  = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        start_test("alu_ops");
        for (i = 1; i <= 6; i++) begin
            rnd = $random(seed);
            send({rnd[31:12], 5'(i), OPC_LUI});
            send(i_type(rnd[11:0], 5'(i), 3'd0, 5'(i), OPC_OP_IMM));
        end
        rnd = $random(seed);
        send({rnd[31:12], 5'd7, OPC_AUIPC});
        for (i = 0; i < 8; i++) begin
            rnd   = $random(seed);
            imm12 = (i == 1 || i == 5) ? {7'd0, rnd[4:0]} : rnd[11:0];
            send(r_type(7'd0, 5'd2, 5'd1, 3'(i), 5'(8 + i)));
            send(i_type(imm12, 5'd3, 3'(i), 5'(16 + i), OPC_OP_IMM));
        end
        send(r_type(7'h20, 5'd4, 5'd5, 3'd0, 5'd24));
        send(r_type(7'h20, 5'd6, 5'd4, 3'd5, 5'd25));
        send(i_type({7'h20, 5'd7}, 5'd5, 3'd5, 5'd26, OPC_OP_IMM));
        finish_test();

        // Write to x0, then read it at distances 1 and 3
        start_test("x0");
        send(i_type(12'h123, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
        send(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd9));
        idle();
        send(i_type(12'h005, 5'd0, 3'd6, 5'd10, OPC_OP_IMM));
        finish_test();

        start_test("forward");
        rnd = $random(seed);
        send(i_type(rnd[11:0], 5'd0, 3'd0, 5'd11, OPC_OP_IMM));
        send(r_type(7'd0, 5'd11, 5'd11, 3'd0, 5'd12));
        send(i_type(rnd[23:12], 5'd0, 3'd0, 5'd13, OPC_OP_IMM));
        send(i_type(12'd1, 5'd0, 3'd0, 5'd14, OPC_OP_IMM));
        send(r_type(7'd0, 5'd13, 5'd12, 3'd4, 5'd15));
        send(i_type(12'd7, 5'd0, 3'd0, 5'd11, OPC_OP_IMM));
        send(i_type(12'd1, 5'd11, 3'd0, 5'd11, OPC_OP_IMM));
        send(r_type(7'd0, 5'd11, 5'd11, 3'd0, 5'd16));
        finish_test();

        // x20 = -1, x21 = x22 = 1, x23 counts fall-through fillers
        start_test("branches");
        send(i_type(12'hfff, 5'd0, 3'd0, 5'd20, OPC_OP_IMM));
        send(i_type(12'd1, 5'd0, 3'd0, 5'd21, OPC_OP_IMM));
        send(i_type(12'd1, 5'd0, 3'd0, 5'd22, OPC_OP_IMM));
        send(i_type(12'd0, 5'd0, 3'd0, 5'd23, OPC_OP_IMM));
        for (i = 0; i < 8; i++) begin
            if (i != 2 && i != 3) begin
                for (k = 0; k < 3; k++) begin
                    rnd  = $random(seed);
                    rs_a = (k == 1) ? 5'd20 : 5'd21;
                    rs_b = (k == 0) ? 5'd22 : ((k == 1) ? 5'd21 : 5'd20);
                    send(b_type({rnd[12:1], 1'b0}, rs_b, rs_a, 3'(i)));
                    send(i_type(12'd1, 5'd23, 3'd0, 5'd23, OPC_OP_IMM));
                end
            end
        end
        finish_test();

        start_test("jumps");
        rnd = $random(seed);
        send(j_type({rnd[20:1], 1'b0}, 5'd24));
        send(i_type(12'd1, 5'd23, 3'd0, 5'd23, OPC_OP_IMM));
        send(r_type(7'd0, 5'd0, 5'd24, 3'd0, 5'd27));
        // Odd base plus even offset
        send(i_type(12'h101, 5'd0, 3'd0, 5'd26, OPC_OP_IMM));
        send(i_type(12'h0f0, 5'd26, 3'd0, 5'd25, OPC_JALR));
        idle();
        rnd = $random(seed);
        send(i_type(rnd[11:0], 5'd27, 3'd0, 5'd28, OPC_JALR));
        send(i_type(12'd1, 5'd23, 3'd0, 5'd23, OPC_OP_IMM));
        finish_test();

        start_test("counters");
        repeat (5) idle();
        send(i_type(12'd3, 5'd0, 3'd0, 5'd29, OPC_OP_IMM));
        idle();
        send(r_type(7'd0, 5'd29, 5'd29, 3'd0, 5'd30));
        finish_test();

        $display("Summary: %0d tests, %0d failing, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, total_errors, dut0.chk0.violations);
        if (tests_failed == 0 && dut0.chk0.violations == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rv_exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_checker #(
    parameter int CTR_WIDTH = 32
) (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          instr_valid,
    input logic [rv_exec_pkg::XLEN-1:0]  instr,
    input rv_exec_pkg::redirect_t        redirect,
    input rv_exec_pkg::retire_t          retire,
    input logic [CTR_WIDTH-1:0]          cycle_count,
    input logic [CTR_WIDTH-1:0]          retire_count
);
    import rv_exec_pkg::*;

    int   violations = 0;
    logic known_op;
    logic accepted;

    // Opcodes the core executes, anything else is a bubble
    assign known_op = instr[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                         OPC_BRANCH, OPC_JAL, OPC_JALR};
    assign accepted = instr_valid && known_op && !redirect.valid;

    // Retire two edges after acceptance, and never otherwise
    retire_timing: assert property (@(posedge clk) disable iff (!arst_n)
        retire.valid == $past(accepted, 2))
    else begin
        $error("retire.valid does not match an instruction accepted two cycles earlier");
        violations++;
    end

    reset_state: assert property (@(posedge clk)
        $rose(arst_n) |-> !redirect.valid && !retire.valid
                          && cycle_count == '0 && retire_count == '0)
    else begin
        $error("outputs or counters not cleared by reset");
        violations++;
    end

    // Sampled during a redirect, so squashed
    squash_no_retire: assert property (@(posedge clk) disable iff (!arst_n)
        $past(redirect.valid && instr_valid, 2) |-> !retire.valid)
    else begin
        $error("instruction sampled during a redirect retired");
        violations++;
    end

endmodule

bind rv_exec_top rv_exec_checker #(.CTR_WIDTH(CTR_WIDTH)) chk0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .redirect    (redirect),
    .retire      (retire),
    .cycle_count (cycle_count),
    .retire_count(retire_count)
);

`default_nettype wire

// File: logic/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
    parameter int CTR_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          instr_valid,
    input  logic [rv_exec_pkg::XLEN-1:0]  instr,
    input  logic [rv_exec_pkg::XLEN-1:0]  pc,
    output rv_exec_pkg::redirect_t        redirect,
    output rv_exec_pkg::retire_t          retire,
    output logic [CTR_WIDTH-1:0]          cycle_count,
    output logic [CTR_WIDTH-1:0]          retire_count
);
    import rv_exec_pkg::*;

    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    issue_t          issue;
    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] x_value;

    // ID
    instr_decoder decoder0 (.instr(instr), .ctrl(ctrl), .imm(imm));

    issue_stage issue0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_valid(instr_valid),
        .pc         (pc),
        .ctrl       (ctrl),
        .imm        (imm),
        .redirect   (redirect),
        .x_issue    (issue),
        .x_value    (x_value),
        .retire     (retire),
        .issue      (issue)
    );

    // X, ALU and branch side by side
    alu alu0 (.issue(issue), .alu_result(alu_result));

    branch_unit branch0 (.issue(issue), .taken(taken), .target(target));

    result_stage #(.CTR_WIDTH(CTR_WIDTH)) result0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .alu_result  (alu_result),
        .taken       (taken),
        .target      (target),
        .redirect    (redirect),
        .x_value     (x_value),
        .retire      (retire),
        .cycle_count (cycle_count),
        .retire_count(retire_count)
    );

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
    parameter int CTR_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  rv_exec_pkg::issue_t           issue,
    input  logic [rv_exec_pkg::XLEN-1:0]  alu_result,
    input  logic                          taken,
    input  logic [rv_exec_pkg::XLEN-1:0]  target,
    output rv_exec_pkg::redirect_t        redirect,
    output logic [rv_exec_pkg::XLEN-1:0]  x_value,
    output rv_exec_pkg::retire_t          retire,
    output logic [CTR_WIDTH-1:0]          cycle_count,
    output logic [CTR_WIDTH-1:0]          retire_count
);
    import rv_exec_pkg::*;

    logic              ret_valid;
    logic [XLEN-1:0]   ret_pc;
    logic [REG_AW-1:0] ret_rd;
    logic [XLEN-1:0]   ret_value;
    logic              ret_we;

    // Link value for jumps
    assign x_value = (issue.ctrl.wb_sel == WB_PC4) ? issue.pc + XLEN'(4) : alu_result;

    assign redirect = '{valid: issue.valid && taken, target: target};

    //////////////////////////////
    // Retire register
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        ret_pc    <= issue.pc;
        ret_rd    <= issue.ctrl.rd;
        ret_value <= x_value;
        ret_we    <= issue.ctrl.reg_we;
    end

    assign retire = '{valid: ret_valid, pc: ret_pc, rd: ret_rd,
                      value: ret_value, reg_we: ret_we};

    //////////////////////////////
    // Performance counters
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count  <= '0;
            retire_count <= '0;
        end else begin
            cycle_count <= cycle_count + CTR_WIDTH'(1);
            if (ret_valid) begin
                retire_count <= retire_count + CTR_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  rv_exec_pkg::issue_t          issue,
    output logic                         taken,
    output logic [rv_exec_pkg::XLEN-1:0] target
);
    import rv_exec_pkg::*;

    logic            eq;
    logic            lt;
    logic            ltu;
    logic            cond;
    logic [XLEN-1:0] jalr_sum;

    assign eq       = issue.rs1_val == issue.rs2_val;
    assign lt       = $signed(issue.rs1_val) < $signed(issue.rs2_val);
    assign ltu      = issue.rs1_val < issue.rs2_val;
    assign jalr_sum = issue.rs1_val + issue.imm;

    always_comb begin
        case (issue.ctrl.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt;
            F3_BGE:  cond = !lt;
            F3_BLTU: cond = ltu;
            F3_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    // Branches and JAL are pc relative
    always_comb begin
        taken  = 1'b0;
        target = issue.pc + issue.imm;
        unique case (issue.ctrl.br_kind)
            BR_BRANCH: taken = issue.valid && cond;
            BR_JAL:    taken = issue.valid;
            BR_JALR: begin
                taken  = issue.valid;
                target = {jalr_sum[XLEN-1:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_exec_pkg::issue_t          issue,
    output logic [rv_exec_pkg::XLEN-1:0] alu_result
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = issue.ctrl.a_sel ? issue.pc  : issue.rs1_val;
    assign op_b  = issue.ctrl.b_sel ? issue.imm : issue.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (issue.ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          instr_valid,
    input  logic [rv_exec_pkg::XLEN-1:0]  pc,
    input  rv_exec_pkg::ctrl_t            ctrl,
    input  logic [rv_exec_pkg::XLEN-1:0]  imm,
    input  rv_exec_pkg::redirect_t        redirect,
    input  rv_exec_pkg::issue_t           x_issue,
    input  logic [rv_exec_pkg::XLEN-1:0]  x_value,
    input  rv_exec_pkg::retire_t          retire,
    output rv_exec_pkg::issue_t           issue
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    logic            x_fwd;
    logic            wb_fwd;
    logic            supported;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    logic            valid_q;
    ctrl_t           ctrl_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] imm_q;

    //////////////////////////////
    // Register file
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (retire.valid && retire.reg_we && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;
        end
    end

    //////////////////////////////
    // Operand forwarding
    //////////////////////////////
    assign x_fwd  = x_issue.valid && x_issue.ctrl.reg_we;
    assign wb_fwd = retire.valid && retire.reg_we;

    // X stage first, then the retiring result, then the array
    function automatic logic [XLEN-1:0] read_operand(input logic [REG_AW-1:0] src);
        logic [XLEN-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (x_fwd && x_issue.ctrl.rd == src) begin
            val = x_value;
        end else if (wb_fwd && retire.rd == src) begin
            val = retire.value;
        end else begin
            val = regs[src];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_operand(ctrl.rs1);
        rs2_val = read_operand(ctrl.rs2);
    end

    // Every supported opcode either writes a register or branches
    assign supported = ctrl.reg_we || (ctrl.br_kind != BR_NONE);

    //////////////////////////////
    // ID/X register
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid && supported && !redirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        ctrl_q <= ctrl;
        pc_q   <= pc;
        rs1_q  <= rs1_val;
        rs2_q  <= rs2_val;
        imm_q  <= imm;
    end

    assign issue = '{valid: valid_q, ctrl: ctrl_q, pc: pc_q,
                     rs1_val: rs1_q, rs2_val: rs2_q, imm: imm_q};

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [rv_exec_pkg::XLEN-1:0] instr,
    output rv_exec_pkg::ctrl_t           ctrl,
    output logic [rv_exec_pkg::XLEN-1:0] imm
);
    import rv_exec_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    alu_op_e         arith_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        unique case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = funct3;
        ctrl.rd     = instr[11:7];
        ctrl.rs1    = instr[19:15];
        ctrl.rs2    = instr[24:20];
        imm         = imm_i;

        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = arith_op;
                ctrl.reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op = arith_op;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
                imm         = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.a_sel  = 1'b1;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
                imm         = imm_u;
            end
            OPC_BRANCH: begin
                ctrl.br_kind = BR_BRANCH;
                imm          = imm_b;
            end
            OPC_JAL: begin
                ctrl.br_kind = BR_JAL;
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_we  = 1'b1;
                imm          = imm_j;
            end
            OPC_JALR: begin
                ctrl.br_kind = BR_JALR;
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_we  = 1'b1;
            end
            // Anything else stays a bubble
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BRANCH, BR_JAL, BR_JALR} br_kind_e;

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    //////////////////////////////
    // Stage payloads
    //////////////////////////////
    typedef struct packed {
        alu_op_e           alu_op;
        logic              a_sel;    // 1 selects pc
        logic              b_sel;    // 1 selects imm
        br_kind_e          br_kind;
        logic [2:0]        funct3;
        wb_sel_e           wb_sel;
        logic              reg_we;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
    } issue_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   value;
        logic              reg_we;
    } retire_t;

endpackage

`default_nettype wire
